/* logic/isa_pkg.sv */
// RV32 instruction formats, ALU opcode and funct encodings, the instruction
// word union and the ALU operation enumeration
`default_nettype none

package isa_pkg;

  // Major opcodes for register-register and register-immediate ALU groups
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;

  // ADD, SUB, MUL and ADDI all share funct3 zero
  localparam logic [2:0] funct3_add = 3'b000;

  // funct7 picks between the plain add, the subtract and the M extension
  localparam logic [6:0] funct7_base   = 7'b0000000;
  localparam logic [6:0] funct7_sub    = 7'b0100000;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  // R-type layout, most significant field first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  // I-type layout, the 12-bit immediate takes the funct7 and rs2 slots
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // One 32-bit word seen through either format
  // The opcode sits in the same bits in both views
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

  // Operations the execute stage knows how to run
  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_MUL = 2'd2
  } alu_op_e;

endpackage

`default_nettype wire

/* logic/exec_pkg.sv */
// Pipeline register and writeback structs plus multiplier timing constants
`default_nettype none

package exec_pkg;

  // Number of radix-4 iterations for a full 32-bit multiplier operand
  localparam int mul_cycles = 16;

  // Width of the multiplier's iteration counter, wide enough to hold mul_cycles
  localparam int mul_cnt_w = $clog2(mul_cycles + 1);

  // Decode to execute pipeline register
  // src_b already holds the sign-extended immediate for ADDI
  typedef struct packed {
    logic             valid;
    isa_pkg::alu_op_e op;
    logic [4:0]       rd;
    logic [31:0]      src_a;
    logic [31:0]      src_b;
  } dec_out_t;

  // Writeback bus from the execute output register
  // It feeds the register file, the hazard check and the core output
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        zero;
  } wb_t;

endpackage

`default_nettype wire

/* logic/reg_file.sv */
// 32x32 integer register file, two async read ports, one write port from
// writeback, x0 tied to zero, write-through bypass on reads
`timescale 1ns/10ps
`default_nettype none

module reg_file
  import exec_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rd_addr_a,
  input  logic [4:0]  rd_addr_b,
  input  wb_t         wr,
  output logic [31:0] rd_data_a,
  output logic [31:0] rd_data_b
);

  logic [31:0] regs [32];

  // Both read ports share this lookup
  // x0 always reads zero, and a write landing this cycle is forwarded
  function automatic logic [31:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0)
      return '0;
    else if (wr.valid && wr.rd == addr)
      return wr.data;
    else
      return regs[addr];
  endfunction

  always_comb
  begin
    rd_data_a = read_port(rd_addr_a);
    rd_data_b = read_port(rd_addr_b);
  end

  // Writes to x0 are dropped so entry zero stays at its reset value
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wr.valid && wr.rd != 5'd0)
    begin
      regs[wr.rd] <= wr.data;
    end
  end

endmodule

`default_nettype wire

/* logic/seq_multiplier.sv */
// Iterative radix-4 shift-add multiplier returning the low 32 product bits
`timescale 1ns/10ps
`default_nettype none

module seq_multiplier
  import exec_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic [31:0] multiplicand,
  input  logic [31:0] multiplier,
  output logic [31:0] product,
  output logic        done
);

  logic [31:0]          mcand;
  logic [31:0]          mplier;
  logic [31:0]          acc;
  logic [31:0]          partial;
  logic [31:0]          acc_next;
  logic [mul_cnt_w-1:0] count;
  logic                 active;

  // The unit is running while iterations remain
  assign active = (count != '0);

  // Multiplicand times the low two multiplier bits, one radix-4 digit
  always_comb
  begin
    case (mplier[1:0])
      2'd0:    partial = '0;
      2'd1:    partial = mcand;
      2'd2:    partial = mcand << 1;
      default: partial = mcand + (mcand << 1);
    endcase
  end

  // Only the low word is kept, so the multiplicand shifts left instead of
  // the accumulator shifting right
  assign acc_next = acc + partial;

  // The last iteration is resolved combinationally so the result is ready
  // mul_cycles edges after start
  assign done    = active && (count == mul_cnt_w'(1));
  assign product = acc_next;

  // Iteration counter
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      count <= '0;
    else if (start)
      count <= mul_cnt_w'(mul_cycles);
    else if (active)
      count <= count - mul_cnt_w'(1);
  end

  // Operand and accumulator datapath
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      mcand  <= multiplicand;
      mplier <= multiplier;
      acc    <= '0;
    end
    else if (active)
    begin
      // Consume two multiplier bits per cycle
      acc    <= acc_next;
      mcand  <= mcand << 2;
      mplier <= mplier >> 2;
    end
  end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
// Decode stage: instruction decode through the format union, RAW hazard check,
// operand read and the decode pipeline register
`timescale 1ns/10ps
`default_nettype none

module decode_stage
  import isa_pkg::*;
  import exec_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid,
  input  instr_u      instr,
  input  logic [31:0] rd_data_a,
  input  logic [31:0] rd_data_b,
  input  logic        exec_busy,
  input  logic [4:0]  exec_rd,
  input  wb_t         wb,
  output logic        ready,
  output logic        illegal,
  output logic [4:0]  rd_addr_a,
  output logic [4:0]  rd_addr_b,
  output dec_out_t    dec
);

  logic        legal;
  logic        is_imm;
  logic        uses_rs2;
  logic        hazard;
  logic        accept;
  logic [4:0]  rd_sel;
  logic [31:0] imm_ext;
  alu_op_e     op;

  // Word decode, the R view is tried first and then the I view
  always_comb
  begin
    legal  = 1'b0;
    is_imm = 1'b0;
    op     = ALU_ADD;
    if (instr.r.opcode == opcode_op && instr.r.funct3 == funct3_add)
    begin
      // funct7 separates ADD, SUB and MUL
      case (instr.r.funct7)
        funct7_base:   legal = 1'b1;
        funct7_sub:
        begin
          legal = 1'b1;
          op    = ALU_SUB;
        end
        funct7_muldiv:
        begin
          legal = 1'b1;
          op    = ALU_MUL;
        end
        default:       legal = 1'b0;
      endcase
    end
    else if (instr.i.opcode == opcode_op_imm && instr.i.funct3 == funct3_add)
    begin
      // ADDI reuses the adder path
      legal  = 1'b1;
      is_imm = 1'b1;
    end
  end

  // rs1 and rd sit in the same bits in both formats
  // rs2 comes through the R view and the immediate through the I view
  assign uses_rs2  = legal && !is_imm;
  assign rd_addr_a = instr.r.rs1;
  assign rd_addr_b = instr.r.rs2;
  assign rd_sel    = instr.r.rd;
  assign imm_ext   = {{20{instr.i.imm[11]}}, instr.i.imm};

  // A nonzero source is pending if an older instruction still owes it:
  // one sitting in dec, a running multiply, or a writeback not yet stored
  function automatic logic pending(input logic [4:0] rs);
    return (rs != 5'd0) &&
           ((dec.valid && dec.rd == rs) ||
            (exec_busy && exec_rd == rs) ||
            (wb.valid && wb.rd == rs));
  endfunction

  // Illegal words carry no sources, so they are never held by a hazard
  always_comb
  begin
    hazard = legal && (pending(rd_addr_a) || (uses_rs2 && pending(rd_addr_b)));
  end

  // Execute takes dec every cycle it is not busy, so dec is free then
  assign ready  = !exec_busy && !hazard;
  assign accept = instr_valid && ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      dec     <= '0;
      illegal <= 1'b0;
    end
    else
    begin
      // One-cycle pulse per dropped word
      illegal <= accept && !legal;
      if (accept && legal)
      begin
        dec.valid <= 1'b1;
        dec.op    <= op;
        dec.rd    <= rd_sel;
        dec.src_a <= rd_data_a;
        dec.src_b <= is_imm ? imm_ext : rd_data_b;
      end
      else if (!exec_busy)
      begin
        // Entry was taken by execute this edge
        dec.valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
// Execute stage: shared add/sub adder, multiplier sequencing, zero flag and
// the writeback output register
`timescale 1ns/10ps
`default_nettype none

module execute_stage
  import isa_pkg::*;
  import exec_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  dec_out_t   dec,
  output logic       exec_busy,
  output logic [4:0] exec_rd,
  output wb_t        wb
);

  logic        take;
  logic        is_mul;
  logic        is_sub;
  logic        mul_start;
  logic        mul_done;
  logic        mul_busy;
  logic [4:0]  mul_rd;
  logic [31:0] b_eff;
  logic [31:0] sum;
  logic [31:0] product;

  // The decode entry is consumed whenever no multiply is in flight
  assign take      = dec.valid && !mul_busy;
  assign is_mul    = (dec.op == ALU_MUL);
  assign is_sub    = (dec.op == ALU_SUB);
  assign mul_start = take && is_mul;

  // Single adder, subtract is a + ~b + 1
  assign b_eff = is_sub ? ~dec.src_b : dec.src_b;
  assign sum   = dec.src_a + b_eff + {31'd0, is_sub};

  seq_multiplier u_mul (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (mul_start),
    .multiplicand (dec.src_a),
    .multiplier   (dec.src_b),
    .product      (product),
    .done         (mul_done)
  );

  // Busy spans from the start edge to the edge that writes the product
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      mul_busy <= 1'b0;
    else if (mul_start)
      mul_busy <= 1'b1;
    else if (mul_done)
      mul_busy <= 1'b0;
  end

  // Destination of the running multiply, used by the hazard check
  always_ff @(posedge clk)
  begin
    if (mul_start)
      mul_rd <= dec.rd;
  end

  assign exec_busy = mul_busy;
  assign exec_rd   = mul_rd;

  // Writeback register
  // An add result and a finished product never land on the same edge,
  // since take is blocked while the multiply runs
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wb <= '0;
    end
    else
    begin
      wb.valid <= 1'b0;
      if (take && !is_mul)
      begin
        wb.valid <= 1'b1;
        wb.rd    <= dec.rd;
        wb.data  <= sum;
        wb.zero  <= (sum == '0);
      end
      else if (mul_done)
      begin
        wb.valid <= 1'b1;
        wb.rd    <= mul_rd;
        wb.data  <= product;
        wb.zero  <= (product == '0);
      end
    end
  end

endmodule

`default_nettype wire

/* logic/exec_core.sv */
// Integer execution slice top: decode stage, register file, execute stage
`timescale 1ns/10ps
`default_nettype none

module exec_core
  import exec_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  output logic        ready,
  output logic        illegal,
  output wb_t         wb
);

  logic [4:0]  rd_addr_a;
  logic [4:0]  rd_addr_b;
  logic [31:0] rd_data_a;
  logic [31:0] rd_data_b;
  logic        exec_busy;
  logic [4:0]  exec_rd;
  dec_out_t    dec;

  // Decode sees the writeback bus both for hazards and through the bypass
  decode_stage u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .exec_busy   (exec_busy),
    .exec_rd     (exec_rd),
    .wb          (wb),
    .ready       (ready),
    .illegal     (illegal),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .dec         (dec)
  );

  // Written from the execute output register
  reg_file u_rf (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .wr        (wb),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b)
  );

  execute_stage u_exec (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (dec),
    .exec_busy (exec_busy),
    .exec_rd   (exec_rd),
    .wb        (wb)
  );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
// Free-running testbench clock source, 100 ns period
`timescale 1ns/10ps
`default_nettype none

module tb_clock
(
  output logic clk
);

  localparam time half_period = 50ns;

  // Start low so the first rising edge lands half a period in
  initial
  begin
    clk = 1'b0;
    forever
      #(half_period) clk = ~clk;
  end

endmodule

`default_nettype wire

/* tests/exec_core_chk.sv */
// Concurrent pipeline assertions for exec_core and the bind that attaches them
`timescale 1ns/10ps
`default_nettype none

module exec_core_chk
  import exec_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     instr_valid,
  input logic     ready,
  input logic     illegal,
  input logic     exec_busy,
  input wb_t      wb,
  input dec_out_t dec
);

  // An entry taken by execute leaves dec unless a new word replaces it
  // This keeps one add result from being written back twice
  a_wb_once: assert property (@(posedge clk) disable iff (!rst_n)
    (dec.valid && !exec_busy && !(instr_valid && ready)) |=> !dec.valid)
    else $error("decode entry stayed valid after execute took it");

  // Decode never accepts while the multiplier holds execute
  a_busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
    exec_busy |-> !ready)
    else $error("ready high while execute is busy");

  // Outputs come out of reset quiet
  a_reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> (!illegal && !wb.valid))
    else $error("illegal or wb.valid set right after reset");

  // The decode register is frozen behind a busy multiply
  a_dec_hold: assert property (@(posedge clk) disable iff (!rst_n)
    exec_busy |=> $stable(dec))
    else $error("dec changed while execute was busy");

endmodule

bind exec_core exec_core_chk u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .instr_valid (instr_valid),
  .ready       (ready),
  .illegal     (illegal),
  .exec_busy   (exec_busy),
  .wb          (wb),
  .dec         (dec)
);

`default_nettype wire

/* tests/tb_exec_core.sv */
// Testbench for exec_core: LFSR stimulus, in-order reference model, writeback
// comparison, illegal pulse tracking and cycle watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_exec_core
  import isa_pkg::*;
  import exec_pkg::*;
;

  localparam int reset_cycles = 10;
  localparam int n_directed   = 80;
  localparam int n_random     = 300;
  localparam int cycle_limit  = 10 + reset_cycles + (n_directed + n_random) * (mul_cycles + 4);

  // Expected writeback plus the cycle it must appear in, when known
  typedef struct packed {
    logic        legal;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        zero;
    logic        timed;
    logic [31:0] due;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic        ready;
  logic        illegal;
  wb_t         wb;

  logic [31:0] model [32];
  logic [31:0] lfsr;
  expect_t     exp_q[$];
  int          illegal_pending;
  int          cyc;

  tb_clock u_clk (.clk(clk));

  exec_core uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .ready       (ready),
    .illegal     (illegal),
    .wb          (wb)
  );

  // Galois LFSR, x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [4:0] rd);
    instr_u u;
    u.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: funct3_add, rd: rd, opcode: opcode_op};
    return u;
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rd);
    instr_u u;
    u.i = '{imm: imm, rs1: rs1, funct3: funct3_add, rd: rd, opcode: opcode_op_imm};
    return u;
  endfunction

  // Expected result of one word against the architectural register state
  function automatic expect_t ref_model(input logic [31:0] regs [32], input logic [31:0] w);
    expect_t     e;
    logic [31:0] a;
    logic [31:0] b;
    e = '0;
    a = (w[19:15] == 5'd0) ? 32'd0 : regs[w[19:15]];
    b = (w[24:20] == 5'd0) ? 32'd0 : regs[w[24:20]];
    e.rd = w[11:7];
    if (w[6:0] == opcode_op && w[14:12] == funct3_add)
    begin
      e.legal = 1'b1;
      if (w[31:25] == funct7_base)
        e.data = a + b;
      else if (w[31:25] == funct7_sub)
        e.data = a - b;
      else if (w[31:25] == funct7_muldiv)
        e.data = a * b;
      else
        e.legal = 1'b0;
    end
    else if (w[6:0] == opcode_op_imm && w[14:12] == funct3_add)
    begin
      e.legal = 1'b1;
      e.data  = a + {{20{w[31]}}, w[31:20]};
    end
    e.zero = (e.data == 32'd0);
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  // Holds the word on the bus until decode accepts it, then books the result
  task automatic issue(input logic [31:0] w);
    expect_t e;
    logic    accepted;
    accepted    = 1'b0;
    instr       = w;
    instr_valid = 1'b1;
    while (!accepted)
    begin
      @(negedge clk);
      #1;
      if (ready)
      begin
        accepted = 1'b1;
        e = ref_model(model, w);
        if (e.legal)
        begin
          // An empty queue means the pipeline is idle, so latency is exact
          e.timed = (exp_q.size() == 0);
          e.due   = cyc + 2 + ((w[31:25] == funct7_muldiv && w[6:0] == opcode_op) ?
                                mul_cycles : 0);
          exp_q.push_back(e);
          if (e.rd != 5'd0)
            model[e.rd] = e.data;
        end
        else
          illegal_pending++;
      end
      @(posedge clk);
      #5;
    end
    instr_valid = 1'b0;
  endtask

  // Random word: about one in eight has a bad opcode, the rest use x0 to x7
  function automatic logic [31:0] random_word();
    logic [31:0] w;
    logic [1:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    if (take_bits(3) == 32'd0)
    begin
      w = take_bits(32);
      w[6:0] = 7'(take_bits(7));
      if (w[6:0] == opcode_op || w[6:0] == opcode_op_imm)
        w[6:0] = 7'h7f;
      return w;
    end
    kind = 2'(take_bits(2));
    rd   = 5'(take_bits(3));
    rs1  = 5'(take_bits(3));
    rs2  = 5'(take_bits(3));
    case (kind)
      2'd0:    w = r_word(funct7_base, rs2, rs1, rd);
      2'd1:    w = r_word(funct7_sub, rs2, rs1, rd);
      2'd2:    w = r_word(funct7_muldiv, rs2, rs1, rd);
      default: w = i_word(12'(take_bits(12)), rs1, rd);
    endcase
    return w;
  endfunction

  // Writebacks and illegal pulses are compared mid-cycle where outputs are settled
  always @(negedge clk)
  begin
    expect_t e;
    if (rst_n)
    begin
      if (wb.valid)
      begin
        if (exp_q.size() == 0)
        begin
          $display("Unexpected writeback to x%0d with no instruction outstanding", wb.rd);
          $display("TEST FAIL");
          $fatal(1);
        end
        e = exp_q.pop_front();
        check_value("wb.rd", 32'(wb.rd), 32'(e.rd));
        check_value("wb.data", wb.data, e.data);
        check_value("wb.zero", 32'(wb.zero), 32'(e.zero));
        if (e.timed)
          check_value("wb.valid cycle", cyc, e.due);
      end
      if (illegal)
      begin
        if (illegal_pending == 0)
        begin
          $display("Illegal pulse seen with no illegal word accepted");
          $display("TEST FAIL");
          $fatal(1);
        end
        illegal_pending--;
      end
    end
  end

  // Cycle counter and watchdog
  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc > cycle_limit)
    begin
      $display("Timeout after %0d cycles, the pipeline stopped making progress", cyc);
      $display("TEST FAIL");
      $fatal(1);
    end
  end

  initial
  begin
    rst_n           = 1'b0;
    instr_valid     = 1'b0;
    instr           = '0;
    lfsr            = 32'd71933;
    illegal_pending = 0;
    cyc             = 0;
    for (int k = 0; k < 32; k++)
      model[k] = '0;
    repeat (reset_cycles) @(posedge clk);
    #5;
    rst_n = 1'b1;
    @(posedge clk);
    #5;

    // x0 as destination and source
    issue(i_word(12'd5, 5'd0, 5'd1));
    issue(r_word(funct7_base, 5'd1, 5'd1, 5'd0));
    issue(r_word(funct7_base, 5'd1, 5'd0, 5'd2));
    issue(r_word(funct7_sub, 5'd0, 5'd1, 5'd3));
    issue(r_word(funct7_sub, 5'd1, 5'd0, 5'd3));
    issue(i_word(12'hfff, 5'd0, 5'd4));
    issue(i_word(12'd7, 5'd0, 5'd0));
    issue(r_word(funct7_base, 5'd0, 5'd0, 5'd5));
    issue(r_word(funct7_sub, 5'd1, 5'd1, 5'd13));

    // Multiply corners, including -2^31 built as -2048 times 2^20
    issue(i_word(12'h800, 5'd0, 5'd7));
    issue(i_word(12'h400, 5'd0, 5'd16));
    issue(r_word(funct7_muldiv, 5'd16, 5'd16, 5'd16));
    issue(r_word(funct7_muldiv, 5'd16, 5'd7, 5'd9));
    issue(r_word(funct7_muldiv, 5'd4, 5'd9, 5'd17));
    issue(r_word(funct7_muldiv, 5'd4, 5'd4, 5'd10));
    issue(r_word(funct7_muldiv, 5'd0, 5'd4, 5'd11));
    issue(r_word(funct7_muldiv, 5'd4, 5'd7, 5'd12));

    // Dependent chains through the stall and the bypass
    for (int k = 0; k < 15; k++)
    begin
      issue(i_word(12'(take_bits(12)), 5'd5, 5'd5));
      issue(r_word(funct7_muldiv, 5'd5, 5'd5, 5'd6));
      issue(r_word(funct7_base, 5'd5, 5'd6, 5'd5));
      issue(r_word(funct7_sub, 5'd6, 5'd5, 5'd14));
    end

    // Random mix with illegal words and idle gaps
    for (int k = 0; k < n_random; k++)
    begin
      issue(random_word());
      if (take_bits(2) == 32'd0)
      begin
        @(posedge clk);
        #5;
      end
    end

    while (exp_q.size() != 0 || illegal_pending != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
logic/isa_pkg.sv
logic/exec_pkg.sv
logic/reg_file.sv
logic/seq_multiplier.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/exec_core.sv
tests/tb_clock.sv
tests/exec_core_chk.sv
tests/tb_exec_core.sv

/* run.sh */
#!/bin/sh
# Build and run the exec_core simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_exec_core \
  --Mdir obj_dir \
  -o sim_exec_core \
  -f compile.f

./obj_dir/sim_exec_core
